// ==== rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    localparam int XLEN = 32;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } rv_opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } rv_alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4,
        WB_NONE
    } rv_wb_sel_e;

    typedef enum logic [1:0] {
        PC_PLUS4,
        PC_BRANCH,
        PC_JAL
    } rv_pc_sel_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
    } rv_fetch_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
        logic [XLEN-1:0] rs2_data;
        logic [4:0]      rd;
        rv_alu_op_e      alu_op;
        logic            mem_en;
        logic            mem_wen;
        rv_wb_sel_e      wb_sel;
    } rv_id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] rs2_data;
        logic [4:0]      rd;
        logic            mem_en;
        logic            mem_wen;
        rv_wb_sel_e      wb_sel;
    } rv_ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] load_data;
        logic [4:0]      rd;
        rv_wb_sel_e      wb_sel;
    } rv_mem_wb_t;

    typedef struct packed {
        rv_pc_sel_e      pc_sel;
        logic [XLEN-1:0] target;
    } rv_redirect_t;

    // Observable result of one retired instruction
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
        logic [4:0]      rd;
        logic            we;
        logic [XLEN-1:0] wdata;
    } rv_retire_t;

endpackage

`default_nettype wire

// ==== rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            we_i,
    input  logic [4:0]      waddr_i,
    input  logic [XLEN-1:0] wdata_i,
    input  logic [4:0]      raddr1_i,
    input  logic [4:0]      raddr2_i,
    output logic [XLEN-1:0] rdata1_o,
    output logic [XLEN-1:0] rdata2_o
);

    logic [XLEN-1:0] regs [32];

    // x0 is never stored
    always_ff @(posedge clk) begin
        if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

    // The wbu drops its write enable for rd x0
    a_no_x0_write: assert property (@(posedge clk) we_i |-> (waddr_i != 5'd0));

endmodule

`default_nettype wire

// ==== rv_ifu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_ifu import rv_core_pkg::*; #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            imem_we_i,
    input  logic [XLEN-1:0] imem_addr_i,
    input  logic [XLEN-1:0] imem_wdata_i,
    input  logic            pc_wen_i,
    input  rv_redirect_t    redirect_i,
    output logic            fetch_valid_o,
    output rv_fetch_t       fetch_o
);

    localparam int IAW = $clog2(IMEM_DEPTH);

    logic [31:0]     imem [IMEM_DEPTH];
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic [31:0]     inst_q;
    logic            start_q;
    logic            issue;

    // First fetch right after reset, then one per retirement
    assign issue = !rst_i && (start_q || pc_wen_i);

    // Redirect stays stable in the idu until the next decode
    always_comb begin
        pc_next = pc_q;
        if (pc_wen_i) begin
            pc_next = (redirect_i.pc_sel == PC_PLUS4) ? pc_q + 32'd4 : redirect_i.target;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q          <= '0;
            start_q       <= 1'b1;
            fetch_valid_o <= 1'b0;
        end else begin
            start_q       <= 1'b0;
            fetch_valid_o <= issue;
            if (issue) begin
                pc_q <= pc_next;
            end
        end
    end

    // Load port takes byte addresses, word aligned
    always_ff @(posedge clk) begin
        if (rst_i && imem_we_i) begin
            imem[imem_addr_i[IAW+1:2]] <= imem_wdata_i;
        end
        if (issue) begin
            inst_q <= imem[pc_next[IAW+1:2]];
        end
    end

    assign fetch_o.pc   = pc_q;
    assign fetch_o.inst = inst_q;

    a_load_in_reset: assert property (@(posedge clk) imem_we_i |-> rst_i);

endmodule

`default_nettype wire

// ==== rv_idu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_idu import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            fetch_valid_i,
    input  rv_fetch_t       fetch_i,
    output logic [4:0]      rs1_addr_o,
    output logic [4:0]      rs2_addr_o,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    output logic            id_valid_o,
    output rv_id_ex_t       id_ex_o,
    output rv_redirect_t    redirect_o
);

    logic [31:0]     inst;
    rv_opcode_e      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_alu_op_e      alu_f;
    logic            rs_eq;
    rv_id_ex_t       dec;
    rv_redirect_t    redir;

    assign inst       = fetch_i.inst;
    assign opcode     = rv_opcode_e'(inst[6:0]);
    assign funct3     = inst[14:12];
    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];
    assign rs_eq      = (rs1_data_i == rs2_data_i);

    // Immediates, sign extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // SUB only exists in the register form
    always_comb begin
        case (funct3)
            3'b000:  alu_f = (opcode == OP && inst[30]) ? ALU_SUB : ALU_ADD;
            3'b010:  alu_f = ALU_SLT;
            3'b100:  alu_f = ALU_XOR;
            3'b110:  alu_f = ALU_OR;
            3'b111:  alu_f = ALU_AND;
            default: alu_f = ALU_ADD;
        endcase
    end

    always_comb begin
        dec          = '0;
        dec.pc       = fetch_i.pc;
        dec.inst     = inst;
        dec.op1      = rs1_data_i;
        dec.op2      = rs2_data_i;
        dec.rs2_data = rs2_data_i;
        dec.rd       = inst[11:7];
        dec.alu_op   = ALU_ADD;
        dec.wb_sel   = WB_NONE;
        redir.pc_sel = PC_PLUS4;
        redir.target = fetch_i.pc + imm_b;
        case (opcode)
            OP: begin
                dec.alu_op = alu_f;
                dec.wb_sel = WB_ALU;
            end
            OP_IMM: begin
                dec.op2    = imm_i;
                dec.alu_op = alu_f;
                dec.wb_sel = WB_ALU;
            end
            LUI: begin
                dec.op2    = imm_u;
                dec.alu_op = ALU_PASS_B;
                dec.wb_sel = WB_ALU;
            end
            LOAD: begin
                dec.op2    = imm_i;
                dec.mem_en = 1'b1;
                dec.wb_sel = WB_MEM;
            end
            STORE: begin
                dec.op2     = imm_s;
                dec.mem_en  = 1'b1;
                dec.mem_wen = 1'b1;
            end
            BRANCH: begin
                // BEQ on funct3 000, BNE on 001
                if ((funct3 == 3'b000 && rs_eq) || (funct3 == 3'b001 && !rs_eq)) begin
                    redir.pc_sel = PC_BRANCH;
                end
            end
            JAL: begin
                dec.wb_sel   = WB_PC4;
                redir.pc_sel = PC_JAL;
                redir.target = fetch_i.pc + imm_j;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_valid_o <= 1'b0;
        end else begin
            id_valid_o <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid_i) begin
            id_ex_o    <= dec;
            redirect_o <= redir;
        end
    end

endmodule

`default_nettype wire

// ==== rv_exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exu import rv_core_pkg::*; (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       id_valid_i,
    input  rv_id_ex_t  id_ex_i,
    output logic       ex_valid_o,
    output rv_ex_mem_t ex_mem_o
);

    logic [XLEN-1:0] result;
    logic            lt;

    assign lt = $signed(id_ex_i.op1) < $signed(id_ex_i.op2);

    // Also the data address for LW and SW
    always_comb begin
        case (id_ex_i.alu_op)
            ALU_SUB:    result = id_ex_i.op1 - id_ex_i.op2;
            ALU_AND:    result = id_ex_i.op1 & id_ex_i.op2;
            ALU_OR:     result = id_ex_i.op1 | id_ex_i.op2;
            ALU_XOR:    result = id_ex_i.op1 ^ id_ex_i.op2;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt};
            ALU_PASS_B: result = id_ex_i.op2;
            default:    result = id_ex_i.op1 + id_ex_i.op2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= id_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid_i) begin
            ex_mem_o.pc       <= id_ex_i.pc;
            ex_mem_o.inst     <= id_ex_i.inst;
            ex_mem_o.result   <= result;
            ex_mem_o.rs2_data <= id_ex_i.rs2_data;
            ex_mem_o.rd       <= id_ex_i.rd;
            ex_mem_o.mem_en   <= id_ex_i.mem_en;
            ex_mem_o.mem_wen  <= id_ex_i.mem_wen;
            ex_mem_o.wb_sel   <= id_ex_i.wb_sel;
        end
    end

endmodule

`default_nettype wire

// ==== rv_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_mem import rv_core_pkg::*; #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       ex_valid_i,
    input  rv_ex_mem_t ex_mem_i,
    output logic       mem_valid_o,
    output rv_mem_wb_t mem_wb_o
);

    localparam int DAW = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0] dmem [DMEM_DEPTH];
    logic [DAW-1:0]  widx;

    // Word index of the byte address
    assign widx = ex_mem_i.result[DAW+1:2];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_valid_o <= 1'b0;
        end else begin
            mem_valid_o <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid_i && ex_mem_i.mem_en && ex_mem_i.mem_wen) begin
            dmem[widx] <= ex_mem_i.rs2_data;
        end
        if (ex_valid_i) begin
            mem_wb_o.pc        <= ex_mem_i.pc;
            mem_wb_o.inst      <= ex_mem_i.inst;
            mem_wb_o.result    <= ex_mem_i.result;
            mem_wb_o.load_data <= dmem[widx];
            mem_wb_o.rd        <= ex_mem_i.rd;
            mem_wb_o.wb_sel    <= ex_mem_i.wb_sel;
        end
    end

    a_word_aligned: assert property (@(posedge clk) disable iff (rst_i)
        (ex_valid_i && ex_mem_i.mem_en) |-> (ex_mem_i.result[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== rv_wbu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_wbu import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            mem_valid_i,
    input  rv_mem_wb_t      mem_wb_i,
    output logic            rf_we_o,
    output logic [4:0]      rf_waddr_o,
    output logic [XLEN-1:0] rf_wdata_o,
    output logic            pc_wen_o,
    output logic            retire_valid_o,
    output rv_retire_t      retire_o
);

    logic [XLEN-1:0] wdata;
    logic            we;

    always_comb begin
        case (mem_wb_i.wb_sel)
            WB_MEM:  wdata = mem_wb_i.load_data;
            WB_PC4:  wdata = mem_wb_i.pc + 32'd4;
            default: wdata = mem_wb_i.result;
        endcase
    end

    // Writes to x0 retire with we low
    assign we = (mem_wb_i.wb_sel != WB_NONE) && (mem_wb_i.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= mem_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid_i) begin
            retire_o.pc    <= mem_wb_i.pc;
            retire_o.inst  <= mem_wb_i.inst;
            retire_o.rd    <= mem_wb_i.rd;
            retire_o.we    <= we;
            retire_o.wdata <= wdata;
        end
    end

    // Register write and PC update land in the retirement cycle
    assign pc_wen_o   = retire_valid_o;
    assign rf_we_o    = retire_valid_o && retire_o.we;
    assign rf_waddr_o = retire_o.rd;
    assign rf_wdata_o = retire_o.wdata;

    // One instruction in flight, so retirements never come back to back
    a_retire_spaced: assert property (@(posedge clk) disable iff (rst_i)
        retire_valid_o |=> !retire_valid_o);

endmodule

`default_nettype wire

// ==== rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_core_pkg::*; #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            imem_we_i,
    input  logic [XLEN-1:0] imem_addr_i,
    input  logic [XLEN-1:0] imem_wdata_i,
    output logic            retire_valid_o,
    output rv_retire_t      retire_o
);

    logic            fetch_valid;
    rv_fetch_t       fetch;
    logic            id_valid;
    rv_id_ex_t       id_ex;
    rv_redirect_t    redirect;
    logic            ex_valid;
    rv_ex_mem_t      ex_mem;
    logic            mem_valid;
    rv_mem_wb_t      mem_wb;
    logic            pc_wen;

    // Register file ports
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [XLEN-1:0] rf_wdata;

    rv_regfile u_regfile (
        .clk      (clk),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    rv_ifu #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_ifu (
        .clk           (clk),
        .rst_i         (rst_i),
        .imem_we_i     (imem_we_i),
        .imem_addr_i   (imem_addr_i),
        .imem_wdata_i  (imem_wdata_i),
        .pc_wen_i      (pc_wen),
        .redirect_i    (redirect),
        .fetch_valid_o (fetch_valid),
        .fetch_o       (fetch)
    );

    rv_idu u_idu (
        .clk           (clk),
        .rst_i         (rst_i),
        .fetch_valid_i (fetch_valid),
        .fetch_i       (fetch),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .id_valid_o    (id_valid),
        .id_ex_o       (id_ex),
        .redirect_o    (redirect)
    );

    rv_exu u_exu (
        .clk        (clk),
        .rst_i      (rst_i),
        .id_valid_i (id_valid),
        .id_ex_i    (id_ex),
        .ex_valid_o (ex_valid),
        .ex_mem_o   (ex_mem)
    );

    rv_mem #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_mem (
        .clk         (clk),
        .rst_i       (rst_i),
        .ex_valid_i  (ex_valid),
        .ex_mem_i    (ex_mem),
        .mem_valid_o (mem_valid),
        .mem_wb_o    (mem_wb)
    );

    rv_wbu u_wbu (
        .clk            (clk),
        .rst_i          (rst_i),
        .mem_valid_i    (mem_valid),
        .mem_wb_i       (mem_wb),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .pc_wen_o       (pc_wen),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_core_pkg::*; ();

    localparam int RESET_CYCLES  = 8;
    localparam int RETIRE_LIMIT  = 20;
    localparam int RETIRE_SPACING = 5;

    logic            clk;
    logic            rst_i;
    logic            imem_we_i;
    logic [XLEN-1:0] imem_addr_i;
    logic [XLEN-1:0] imem_wdata_i;
    logic            retire_valid;
    rv_retire_t      retire;

    logic [31:0] prog [$];
    int          seed = 50843;
    string       cur_test;
    int          test_err;
    int          passes;
    int          fails;

    rv_core_top #(
        .IMEM_DEPTH (256),
        .DMEM_DEPTH (256)
    ) dut_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .imem_we_i      (imem_we_i),
        .imem_addr_i    (imem_addr_i),
        .imem_wdata_i   (imem_wdata_i),
        .retire_valid_o (retire_valid),
        .retire_o       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // RV32I encoders
    function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, rv_opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] b_type(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, LUI};
    endfunction

    function automatic logic [31:0] j_type(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    function automatic logic [XLEN-1:0] sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic rv_retire_t rec(logic [XLEN-1:0] pc, logic [31:0] inst, logic [4:0] rd,
                                       logic we, logic [XLEN-1:0] wdata);
        rv_retire_t r;
        r.pc    = pc;
        r.inst  = inst;
        r.rd    = rd;
        r.we    = we;
        r.wdata = wdata;
        return r;
    endfunction

    // rd and wdata carry no meaning when nothing is written
    task automatic check_retire(string what, rv_retire_t exp, rv_retire_t act);
        string expected;
        if (act.pc !== exp.pc || act.inst !== exp.inst || act.we !== exp.we ||
            (exp.we && (act.rd !== exp.rd || act.wdata !== exp.wdata))) begin
            expected = $sformatf("expected pc=%h inst=%h rd=%0d we=%b wdata=%h",
                                 exp.pc, exp.inst, exp.rd, exp.we, exp.wdata);
            $display("** Error %s %s: %s, actual pc=%h inst=%h rd=%0d we=%b wdata=%h",
                     cur_test, what, expected, act.pc, act.inst, act.rd, act.we, act.wdata);
            test_err++;
        end
    endtask

    task automatic check_pc(string what, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("** Error %s %s: expected pc %h, actual pc %h", cur_test, what, exp, act);
            test_err++;
        end
    endtask

    task automatic check_gap(string what, int exp, int act);
        if (act != exp) begin
            $display("** Error %s %s: expected %0d cycles, actual %0d", cur_test, what, exp, act);
            test_err++;
        end
    endtask

    // Counts falling edges until a retirement shows up
    task automatic wait_retire(output rv_retire_t r, output int gap);
        int  n;
        bit  seen;
        n    = 0;
        seen = 1'b0;
        r    = '0;
        gap  = -1;
        while (!seen && n < RETIRE_LIMIT) begin
            @(negedge clk);
            n++;
            if (retire_valid) begin
                seen = 1'b1;
                r    = retire;
                gap  = n;
            end
        end
        if (!seen) begin
            $display("Timeout in %s: no instruction retired within %0d cycles", cur_test,
                     RETIRE_LIMIT);
            test_err++;
        end
    endtask

    task automatic expect_retire(string what, rv_retire_t exp);
        rv_retire_t act;
        int         gap;
        wait_retire(act, gap);
        if (gap > 0) begin
            check_retire(what, exp, act);
        end
    endtask

    // Reset stays high for at least 8 cycles and until the program is in
    task automatic load_program;
        int cycles;
        cycles = 0;
        @(posedge clk);
        rst_i <= 1'b1;
        foreach (prog[i]) begin
            @(posedge clk);
            imem_we_i    <= 1'b1;
            imem_addr_i  <= 32'(i * 4);
            imem_wdata_i <= prog[i];
            cycles++;
        end
        @(posedge clk);
        imem_we_i <= 1'b0;
        cycles++;
        while (cycles < RESET_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
    endtask

    task automatic start_test(string name);
        cur_test = name;
        test_err = 0;
        prog     = {};
    endtask

    task automatic finish_test;
        if (test_err == 0) begin
            $display("%s: pass", cur_test);
            passes++;
        end else begin
            $display("%s: FAIL with %0d errors", cur_test, test_err);
            fails++;
        end
    endtask

    task automatic alu_ops;
        logic [11:0]     ia;
        logic [11:0]     ib;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res [8];
        start_test("alu_ops");
        ia = 12'($random(seed));
        ib = 12'($random(seed));
        a  = sext12(ia);
        b  = sext12(ib);
        prog.push_back(i_type(ia, 0, 3'b000, 1, OP_IMM));
        prog.push_back(i_type(ib, 0, 3'b000, 2, OP_IMM));
        prog.push_back(r_type(7'h00, 2, 1, 3'b000, 3));
        prog.push_back(r_type(7'h20, 2, 1, 3'b000, 4));
        prog.push_back(r_type(7'h00, 2, 1, 3'b111, 5));
        prog.push_back(r_type(7'h00, 2, 1, 3'b110, 6));
        prog.push_back(r_type(7'h00, 2, 1, 3'b100, 7));
        prog.push_back(r_type(7'h00, 2, 1, 3'b010, 8));
        prog.push_back(j_type(21'd0, 0));
        res = '{a, b, a + b, a - b, a & b, a | b, a ^ b, 32'($signed(a) < $signed(b))};
        load_program;
        for (int i = 0; i < 8; i++) begin
            expect_retire($sformatf("inst %0d", i),
                          rec(32'(i * 4), prog[i], 5'(i + 1), 1'b1, res[i]));
        end
        finish_test;
    endtask

    task automatic x0_writes;
        logic [11:0] imm;
        start_test("x0_writes");
        imm = 12'($random(seed));
        prog.push_back(i_type(imm, 0, 3'b000, 0, OP_IMM));
        prog.push_back(r_type(7'h00, 0, 0, 3'b000, 5));
        prog.push_back(i_type(imm, 0, 3'b000, 6, OP_IMM));
        prog.push_back(j_type(21'd0, 0));
        load_program;
        expect_retire("addi x0", rec(0, prog[0], 0, 1'b0, '0));
        expect_retire("add x5 x0 x0", rec(4, prog[1], 5, 1'b1, '0));
        expect_retire("addi x6 x0", rec(8, prog[2], 6, 1'b1, sext12(imm)));
        finish_test;
    endtask

    task automatic load_store;
        logic [11:0] va;
        logic [11:0] vb;
        start_test("load_store");
        va = 12'($random(seed));
        vb = ~va;
        prog.push_back(i_type(12'h040, 0, 3'b000, 1, OP_IMM));
        prog.push_back(i_type(va, 0, 3'b000, 2, OP_IMM));
        prog.push_back(i_type(vb, 0, 3'b000, 3, OP_IMM));
        prog.push_back(s_type(12'd0, 2, 1));
        prog.push_back(s_type(12'd4, 3, 1));
        prog.push_back(i_type(12'd0, 1, 3'b010, 4, LOAD));
        prog.push_back(i_type(12'd4, 1, 3'b010, 5, LOAD));
        prog.push_back(j_type(21'd0, 0));
        load_program;
        expect_retire("addi x1", rec(0, prog[0], 1, 1'b1, 32'h40));
        expect_retire("addi x2", rec(4, prog[1], 2, 1'b1, sext12(va)));
        expect_retire("addi x3", rec(8, prog[2], 3, 1'b1, sext12(vb)));
        expect_retire("sw 0", rec(12, prog[3], 0, 1'b0, '0));
        expect_retire("sw 4", rec(16, prog[4], 0, 1'b0, '0));
        expect_retire("lw 0", rec(20, prog[5], 4, 1'b1, sext12(va)));
        expect_retire("lw 4", rec(24, prog[6], 5, 1'b1, sext12(vb)));
        finish_test;
    endtask

    task automatic branches;
        logic [XLEN-1:0] x1;
        logic [XLEN-1:0] pc;
        rv_retire_t      act;
        int              gap;
        bit              taken [4];
        start_test("branches");
        x1 = 32'd5;
        prog.push_back(i_type(12'd5, 0, 3'b000, 1, OP_IMM));
        prog.push_back(b_type(13'd8, 0, 0, 3'b000));
        prog.push_back(i_type(12'd1, 0, 3'b000, 2, OP_IMM));
        prog.push_back(b_type(13'd8, 0, 1, 3'b001));
        prog.push_back(i_type(12'd2, 0, 3'b000, 2, OP_IMM));
        prog.push_back(b_type(13'd8, 0, 1, 3'b000));
        prog.push_back(b_type(13'd8, 0, 0, 3'b001));
        prog.push_back(j_type(21'd0, 0));
        // BEQ x0,x0 then BNE x1,x0 then BEQ x1,x0 then BNE x0,x0
        taken = '{1'b1, x1 != 0, x1 == 0, 1'b0};
        load_program;
        wait_retire(act, gap);
        check_pc("addi", 0, act.pc);
        pc = 32'd4;
        for (int i = 0; i < 4; i++) begin
            wait_retire(act, gap);
            check_pc($sformatf("branch %0d", i), pc, act.pc);
            pc = taken[i] ? pc + 32'd8 : pc + 32'd4;
        end
        wait_retire(act, gap);
        check_pc("after branches", pc, act.pc);
        finish_test;
    endtask

    task automatic jal_lui;
        logic [19:0] uimm;
        rv_retire_t  act;
        int          gap;
        start_test("jal_lui");
        uimm = 20'($random(seed));
        prog.push_back(u_type(uimm, 2));
        prog.push_back(j_type(21'd12, 1));
        prog.push_back(i_type(12'd1, 0, 3'b000, 3, OP_IMM));
        prog.push_back(i_type(12'd2, 0, 3'b000, 3, OP_IMM));
        prog.push_back(i_type(12'd0, 1, 3'b000, 4, OP_IMM));
        prog.push_back(j_type(21'd0, 0));
        load_program;
        expect_retire("lui", rec(0, prog[0], 2, 1'b1, {uimm, 12'h000}));
        expect_retire("jal", rec(4, prog[1], 1, 1'b1, 32'd8));
        wait_retire(act, gap);
        check_pc("jal target", 32'd4 + 32'd12, act.pc);
        check_retire("addi x4 x1", rec(16, prog[4], 4, 1'b1, 32'd8), act);
        finish_test;
    endtask

    task automatic retire_timing;
        rv_retire_t act;
        int         gap;
        start_test("retire_timing");
        prog.push_back(i_type(12'd1, 0, 3'b000, 1, OP_IMM));
        prog.push_back(i_type(12'd1, 1, 3'b000, 2, OP_IMM));
        prog.push_back(i_type(12'd1, 2, 3'b000, 3, OP_IMM));
        prog.push_back(j_type(21'd0, 0));
        load_program;
        for (int i = 0; i < 4; i++) begin
            wait_retire(act, gap);
            if (gap > 0) begin
                check_gap($sformatf("spacing %0d", i), RETIRE_SPACING, gap);
                check_pc($sformatf("retire %0d", i), 32'(i * 4), act.pc);
            end
        end
        finish_test;
    endtask

    initial begin
        rst_i        = 1'b1;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;
        passes       = 0;
        fails        = 0;
        alu_ops;
        x0_writes;
        load_store;
        branches;
        jal_lui;
        retire_timing;
        $display("Summary: %0d tests, %0d passed, %0d failed", passes + fails, passes, fails);
        if (fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rv_core_pkg.sv
rv_regfile.sv
rv_ifu.sv
rv_idu.sv
rv_exu.sv
rv_mem.sv
rv_wbu.sv
rv_core_top.sv
tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the RV32I core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module tb_rv_core -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -x "test passed" > /dev/null \
    || exit 1
